/* verilog.f */
+incdir+.
ccu_pkg.sv
ccu_ifs.sv
ccu_ifq_entry.sv
ccu_ifq.sv
ccu_beat_counter.sv
ccu_fill_fsm.sv
ccu_line_buffer.sv
ccu_top.sv
tb_ccu.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f verilog.f --top-module tb_ccu \
    && ./obj_dir/Vtb_ccu \
    || exit 1

/* tb_ccu.sv */
`default_nettype none

`include "ccu_settings.svh"

module tb_ccu;
    timeunit 1ns;
    timeprecision 1ps;

    import ccu_pkg::*;

    localparam int         CLK_HALF      = 50;
    localparam int         DRV_DLY       = 5;
    localparam int         REQ_TIMEOUT   = 200;
    localparam int         DRAIN_TIMEOUT = 2000;
    localparam line_addr_t BASE_ADDR     = 27'h004_a10;
    localparam logic [`CCU_BUS_DATA_WIDTH-1:0] BEAT_SALT = 64'h9e37_79b9_7f4a_7c15;

    logic                           clk;
    logic                           i_reset;
    logic                           i_miss_valid;
    line_addr_t                     i_miss_addr;
    logic                           o_miss_full;
    logic                           o_bus_req;
    line_addr_t                     o_bus_addr;
    logic                           i_bus_ack;
    logic                           i_bus_data_valid;
    logic [`CCU_BUS_DATA_WIDTH-1:0] i_bus_data;
    logic                           o_fill_valid;
    line_addr_t                     o_fill_addr;
    line_data_t                     o_fill_data;

    // Accepted lines not yet filled, oldest first
    line_addr_t  exp_q[$];
    int          alloc_count = 0;
    int          req_count   = 0;
    logic [31:0] lcg_state   = 32'd82;

    ccu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % n;
    endfunction

    function automatic line_addr_t line_at(input int n);
        return BASE_ADDR + line_addr_t'(n);
    endfunction

    // Memory contents: line address in both halves, salted per beat
    function automatic logic [`CCU_BUS_DATA_WIDTH-1:0] mem_beat(input line_addr_t addr,
                                                               input int idx);
        logic [31:0] half;
        half = 32'(addr);
        return {half, half} ^ (64'(idx) * BEAT_SALT);
    endfunction

    function automatic line_data_t ref_line(input line_addr_t addr);
        line_data_t line;
        line = '0;
        for (int b = 0; b < `CCU_BEATS_PER_LINE; b++) begin
            line[b*`CCU_BUS_DATA_WIDTH +: `CCU_BUS_DATA_WIDTH] = mem_beat(addr, b);
        end
        return line;
    endfunction

    function automatic bit is_pending(input line_addr_t addr);
        foreach (exp_q[i]) begin
            if (exp_q[i] == addr) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_low(input string name, input logic value);
        assert (value == 1'b0) else
            fail_run($sformatf("ERROR: %s got 0x%h, expected 0x0", name, value));
    endtask

    task automatic check_counts();
        assert (req_count == alloc_count) else
            fail_run($sformatf("ERROR: bus requests got 0x%h, expected 0x%h",
                               req_count, alloc_count));
    endtask

    // Called 5 ns after a rising edge, returns at the same point one cycle later
    task automatic send_miss(input line_addr_t addr);
        assert (o_miss_full == (exp_q.size() == `CCU_IFQ_DEPTH)) else
            fail_run($sformatf("ERROR: o_miss_full got 0x%h, expected 0x%h",
                               o_miss_full, exp_q.size() == `CCU_IFQ_DEPTH));
        if (exp_q.size() < `CCU_IFQ_DEPTH && !is_pending(addr)) begin
            exp_q.push_back(addr);
            alloc_count++;
        end
        i_miss_valid = 1'b1;
        i_miss_addr  = addr;
        @(posedge clk);
        #DRV_DLY;
        i_miss_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #DRV_DLY;
            cycles++;
            assert (cycles < DRAIN_TIMEOUT) else
                fail_run("Timeout: pending misses were not filled in time");
        end
    endtask

    // Bus slave with a random ack delay and random gaps between beats
    task automatic serve_request();
        line_addr_t addr;
        addr = o_bus_addr;
        assert (exp_q.size() != 0) else fail_run("Bus request raised with no pending miss");
        assert (addr == exp_q[0]) else
            fail_run($sformatf("ERROR: o_bus_addr got 0x%h, expected 0x%h", addr, exp_q[0]));
        req_count++;
        repeat (rand_below(6)) begin
            @(posedge clk);
            #DRV_DLY;
            assert (o_bus_req) else fail_run("ERROR: o_bus_req got 0x0, expected 0x1");
        end
        i_bus_ack = 1'b1;
        @(posedge clk);
        #DRV_DLY;
        i_bus_ack = 1'b0;
        check_low("o_bus_req", o_bus_req);
        for (int b = 0; b < `CCU_BEATS_PER_LINE; b++) begin
            repeat (rand_below(4)) begin
                @(posedge clk);
                #DRV_DLY;
            end
            i_bus_data_valid = 1'b1;
            i_bus_data       = mem_beat(addr, b);
            @(posedge clk);
            #DRV_DLY;
            i_bus_data_valid = 1'b0;
        end
    endtask

    initial begin : bus_model
        int idle;
        idle = 0;
        forever begin
            @(posedge clk);
            #DRV_DLY;
            if (o_bus_req) begin
                serve_request();
                idle = 0;
            end else if (exp_q.size() != 0) begin
                idle++;
                assert (idle < REQ_TIMEOUT) else
                    fail_run("Timeout: a pending miss never raised a bus request");
            end
        end
    end

    // Fill outputs are sampled mid-cycle
    initial begin : compare_fills
        logic fill_prev;
        fill_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (!i_reset && o_fill_valid) begin
                assert (!fill_prev) else fail_run("o_fill_valid stayed high for two cycles");
                assert (exp_q.size() != 0) else fail_run("Fill pulse with no pending miss");
                assert (o_fill_addr == exp_q[0]) else
                    fail_run($sformatf("ERROR: o_fill_addr got 0x%h, expected 0x%h",
                                       o_fill_addr, exp_q[0]));
                assert (o_fill_data == ref_line(exp_q[0])) else
                    fail_run($sformatf("ERROR: o_fill_data got 0x%h, expected 0x%h",
                                       o_fill_data, ref_line(exp_q[0])));
                void'(exp_q.pop_front());
            end
            fill_prev = o_fill_valid;
        end
    end

    initial begin : stimulus
        i_reset          = 1'b1;
        i_miss_valid     = 1'b0;
        i_miss_addr      = '0;
        i_bus_ack        = 1'b0;
        i_bus_data_valid = 1'b0;
        i_bus_data       = '0;
        repeat (10) @(posedge clk);
        #DRV_DLY;
        i_reset = 1'b0;
        check_low("o_bus_req", o_bus_req);
        check_low("o_fill_valid", o_fill_valid);
        check_low("o_miss_full", o_miss_full);

        // Single miss, then three in a row
        send_miss(line_at(0));
        wait_drain();
        check_counts();
        for (int n = 1; n <= 3; n++) send_miss(line_at(n));
        wait_drain();
        check_counts();

        // Repeated misses to one line merge
        send_miss(line_at(4));
        send_miss(line_at(4));
        repeat (3) @(posedge clk);
        #DRV_DLY;
        send_miss(line_at(4));
        wait_drain();
        check_counts();

        // Fill the queue, then a miss that must be dropped
        for (int n = 5; n <= 8; n++) send_miss(line_at(n));
        assert (o_miss_full) else fail_run("ERROR: o_miss_full got 0x0, expected 0x1");
        send_miss(line_at(9));
        wait_drain();
        check_counts();

        // Random traffic over a small set of lines
        for (int n = 0; n < 40; n++) begin
            send_miss(line_at(16 + int'(rand_below(8))));
            repeat (rand_below(3)) begin
                @(posedge clk);
                #DRV_DLY;
            end
        end
        wait_drain();

        // Quiet window so a late extra request or fill still shows up
        repeat (8) begin
            @(posedge clk);
            #DRV_DLY;
        end
        check_counts();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* ccu_top.sv */
`default_nettype none

`include "ccu_settings.svh"

module ccu_top (
    input  logic                           clk,
    input  logic                           i_reset,

    // Instruction cache misses
    input  logic                           i_miss_valid,
    input  ccu_pkg::line_addr_t            i_miss_addr,
    output logic                           o_miss_full,

    // Memory bus request
    output logic                           o_bus_req,
    output ccu_pkg::line_addr_t            o_bus_addr,
    input  logic                           i_bus_ack,

    // Memory bus data beats
    input  logic                           i_bus_data_valid,
    input  logic [`CCU_BUS_DATA_WIDTH-1:0] i_bus_data,

    // Line fill towards the instruction cache
    output logic                           o_fill_valid,
    output ccu_pkg::line_addr_t            o_fill_addr,
    output ccu_pkg::line_data_t            o_fill_data
);

    ifq_head_if  ifq_head ();
    fill_beat_if fill_beat ();

    assign fill_beat.beat_valid = i_bus_data_valid;
    assign fill_beat.beat_data  = i_bus_data;
    assign o_miss_full          = ifq_head.full;

    ccu_ifq #(
        .OPTN_ADDR_WIDTH (`CCU_ADDR_WIDTH)
    ) ifq_i (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_miss_valid (i_miss_valid),
        .i_miss_addr  (i_miss_addr),
        .ifq_head     (ifq_head.queue)
    );

    ccu_fill_fsm fill_fsm_i (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_bus_ack    (i_bus_ack),
        .ifq_head     (ifq_head.fsm),
        .fill_beat    (fill_beat.fsm),
        .o_bus_req    (o_bus_req),
        .o_bus_addr   (o_bus_addr),
        .o_fill_valid (o_fill_valid),
        .o_fill_addr  (o_fill_addr)
    );

    ccu_beat_counter beat_counter_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .fill_beat (fill_beat.counter)
    );

    ccu_line_buffer line_buffer_i (
        .clk       (clk),
        .i_reset   (i_reset),
        .fill_beat (fill_beat.buffer),
        .o_line    (o_fill_data)
    );

endmodule

`default_nettype wire

/* ccu_line_buffer.sv */
`default_nettype none

`include "ccu_settings.svh"

module ccu_line_buffer (
    input  logic                clk,
    input  logic                i_reset,
    fill_beat_if.buffer         fill_beat,
    output ccu_pkg::line_data_t o_line
);

    import ccu_pkg::*;

    localparam int IDX_WIDTH = $clog2(`CCU_BEATS_PER_LINE);
    localparam logic [IDX_WIDTH-1:0] IDX_LAST = IDX_WIDTH'(`CCU_BEATS_PER_LINE - 1);

    logic [IDX_WIDTH-1:0] wr_idx_r;
    line_data_t           line_r;
    logic                 beat_take;

    assign beat_take = fill_beat.collect && fill_beat.beat_valid;

    // Slice index for the next beat
    always_ff @(posedge clk) begin
        if (i_reset || fill_beat.clear) begin
            wr_idx_r <= '0;
        end else if (beat_take) begin
            wr_idx_r <= (wr_idx_r == IDX_LAST) ? '0 : wr_idx_r + 1'b1;
        end
    end

    // Beat 0 lands in the low bits of the line
    always_ff @(posedge clk) begin
        if (beat_take) begin
            line_r[wr_idx_r*`CCU_BUS_DATA_WIDTH +: `CCU_BUS_DATA_WIDTH] <= fill_beat.beat_data;
        end
    end

    assign o_line = line_r;

endmodule

`default_nettype wire

/* ccu_fill_fsm.sv */
`default_nettype none

module ccu_fill_fsm (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_bus_ack,
    ifq_head_if.fsm             ifq_head,
    fill_beat_if.fsm            fill_beat,
    output logic                o_bus_req,
    output ccu_pkg::line_addr_t o_bus_addr,
    output logic                o_fill_valid,
    output ccu_pkg::line_addr_t o_fill_addr
);

    import ccu_pkg::*;

    fill_state_t state_r;
    fill_state_t state_next;
    line_addr_t  fill_addr_r;
    logic        bus_req_r;
    logic        fill_start;

    // New fill begins when idle and a miss is pending
    assign fill_start = (state_r == FILL_IDLE) && ifq_head.head_valid;

    always_comb begin
        state_next = state_r;
        unique case (state_r)
            FILL_IDLE: begin
                if (ifq_head.head_valid) begin
                    state_next = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (i_bus_ack) begin
                    state_next = FILL_DATA;
                end
            end
            FILL_DATA: begin
                if (fill_beat.beat_last) begin
                    state_next = FILL_DONE;
                end
            end
            FILL_DONE: begin
                state_next = FILL_IDLE;
            end
            default: begin
                state_next = FILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= FILL_IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    // Head entry stays put until retired, latch it once per fill
    always_ff @(posedge clk) begin
        if (fill_start) begin
            fill_addr_r <= ifq_head.head_addr;
        end
    end

    // Request raised with the move to REQ, dropped on ack
    always_ff @(posedge clk) begin
        if (i_reset) begin
            bus_req_r <= 1'b0;
        end else if (fill_start) begin
            bus_req_r <= 1'b1;
        end else if (i_bus_ack) begin
            bus_req_r <= 1'b0;
        end
    end

    assign o_bus_req    = bus_req_r;
    assign o_bus_addr   = fill_addr_r;
    assign o_fill_valid = (state_r == FILL_DONE);
    assign o_fill_addr  = fill_addr_r;

    assign ifq_head.retire  = (state_r == FILL_DONE);
    assign fill_beat.collect = (state_r == FILL_DATA);
    assign fill_beat.clear   = fill_start;

    // Request only in REQ, and only for the line still at the queue head
    a_req_only_in_req: assert property (
        @(posedge clk) disable iff (i_reset)
        o_bus_req |-> (state_r == FILL_REQ) && ifq_head.head_valid
                      && (ifq_head.head_addr == fill_addr_r)
    );

endmodule

`default_nettype wire

/* ccu_beat_counter.sv */
`default_nettype none

`include "ccu_settings.svh"

module ccu_beat_counter (
    input  logic         clk,
    input  logic         i_reset,
    fill_beat_if.counter fill_beat
);

    localparam int CNT_WIDTH = $clog2(`CCU_BEATS_PER_LINE);
    localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(`CCU_BEATS_PER_LINE - 1);

    logic [CNT_WIDTH-1:0] beat_cnt_r;
    logic                 beat_take;

    // Beats only count while the sequencer is collecting
    assign beat_take = fill_beat.collect && fill_beat.beat_valid;

    assign fill_beat.beat_last = beat_take && (beat_cnt_r == CNT_LAST);

    always_ff @(posedge clk) begin
        if (i_reset || fill_beat.clear) begin
            beat_cnt_r <= '0;
        end else if (fill_beat.beat_last) begin
            beat_cnt_r <= '0;
        end else if (beat_take) begin
            beat_cnt_r <= beat_cnt_r + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* ccu_ifq.sv */
`default_nettype none

`include "ccu_settings.svh"

module ccu_ifq #(
    parameter  int OPTN_ADDR_WIDTH = `CCU_ADDR_WIDTH,
    localparam int LINE_ADDR_WIDTH = OPTN_ADDR_WIDTH - `CCU_IC_OFFSET_WIDTH
) (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_miss_valid,
    input  logic [LINE_ADDR_WIDTH-1:0] i_miss_addr,
    ifq_head_if.queue                  ifq_head
);

    localparam int PTR_WIDTH = $clog2(`CCU_IFQ_DEPTH);
    localparam logic [PTR_WIDTH-1:0] PTR_LAST = PTR_WIDTH'(`CCU_IFQ_DEPTH - 1);

    logic [`CCU_IFQ_DEPTH-1:0]  entry_valid;
    logic [LINE_ADDR_WIDTH-1:0] entry_addr [`CCU_IFQ_DEPTH];
    logic [`CCU_IFQ_DEPTH-1:0]  entry_alloc;
    logic [`CCU_IFQ_DEPTH-1:0]  entry_done;
    logic [PTR_WIDTH-1:0]       head_ptr_r;
    logic [PTR_WIDTH-1:0]       tail_ptr_r;
    logic                       miss_dup;
    logic                       ifq_full;
    logic                       alloc_en;

    // A miss to a line already pending is merged
    always_comb begin
        miss_dup = 1'b0;
        for (int i = 0; i < `CCU_IFQ_DEPTH; i++) begin
            if (entry_valid[i] && (entry_addr[i] == i_miss_addr)) begin
                miss_dup = 1'b1;
            end
        end
    end

    assign ifq_full = &entry_valid;
    assign alloc_en = i_miss_valid && !ifq_full && !miss_dup;

    // Entries are allocated and retired in order, so two pointers
    // are enough to find the oldest pending line
    always_ff @(posedge clk) begin
        if (i_reset) begin
            tail_ptr_r <= '0;
            head_ptr_r <= '0;
        end else begin
            if (alloc_en) begin
                tail_ptr_r <= (tail_ptr_r == PTR_LAST) ? '0 : tail_ptr_r + 1'b1;
            end
            if (ifq_head.retire) begin
                head_ptr_r <= (head_ptr_r == PTR_LAST) ? '0 : head_ptr_r + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < `CCU_IFQ_DEPTH; i++) begin : g_entry
        assign entry_alloc[i] = alloc_en && (tail_ptr_r == PTR_WIDTH'(i));
        assign entry_done[i]  = ifq_head.retire && (head_ptr_r == PTR_WIDTH'(i));

        ccu_ifq_entry #(
            .OPTN_ADDR_WIDTH (OPTN_ADDR_WIDTH)
        ) ifq_entry_i (
            .clk               (clk),
            .i_reset           (i_reset),
            .i_alloc_en        (entry_alloc[i]),
            .i_alloc_addr      (i_miss_addr),
            .i_ccu_done        (entry_done[i]),
            .o_ifq_entry_valid (entry_valid[i]),
            .o_ifq_entry_addr  (entry_addr[i])
        );
    end

    // Head slot
    assign ifq_head.head_valid = entry_valid[head_ptr_r];
    assign ifq_head.head_addr  = entry_addr[head_ptr_r];
    assign ifq_head.full       = ifq_full;

    // Fill sequencer only retires a line it took from a valid head
    a_retire_needs_head: assert property (
        @(posedge clk) disable iff (i_reset)
        ifq_head.retire |-> ifq_head.head_valid
    );

endmodule

`default_nettype wire

/* ccu_ifq_entry.sv */
`default_nettype none

`include "ccu_settings.svh"

module ccu_ifq_entry #(
    parameter  int OPTN_ADDR_WIDTH = `CCU_ADDR_WIDTH,
    localparam int LINE_ADDR_WIDTH = OPTN_ADDR_WIDTH - `CCU_IC_OFFSET_WIDTH
) (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_alloc_en,
    input  logic [LINE_ADDR_WIDTH-1:0] i_alloc_addr,
    input  logic                       i_ccu_done,
    output logic                       o_ifq_entry_valid,
    output logic [LINE_ADDR_WIDTH-1:0] o_ifq_entry_addr
);

    localparam logic ENTRY_INVALID = 1'b0;
    localparam logic ENTRY_VALID   = 1'b1;

    logic                       entry_state_r;
    logic                       entry_state_next;
    logic [LINE_ADDR_WIDTH-1:0] entry_addr_r;

    // Invalid until allocated, valid until the fill retires it
    always_comb begin
        entry_state_next = entry_state_r;
        if ((entry_state_r == ENTRY_INVALID) && i_alloc_en) begin
            entry_state_next = ENTRY_VALID;
        end else if ((entry_state_r == ENTRY_VALID) && i_ccu_done) begin
            entry_state_next = ENTRY_INVALID;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            entry_state_r <= ENTRY_INVALID;
        end else begin
            entry_state_r <= entry_state_next;
        end
    end

    // Line address captured on allocation
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            entry_addr_r <= i_alloc_addr;
        end
    end

    assign o_ifq_entry_valid = (entry_state_r == ENTRY_VALID);
    assign o_ifq_entry_addr  = entry_addr_r;

    // The queue only allocates into free slots
    a_no_alloc_when_valid: assert property (
        @(posedge clk) disable iff (i_reset)
        i_alloc_en |-> (entry_state_r == ENTRY_INVALID)
    );

endmodule

`default_nettype wire

/* ccu_ifs.sv */
`default_nettype none

`include "ccu_settings.svh"

// Oldest pending miss, presented by the queue to the fill sequencer
interface ifq_head_if;
    import ccu_pkg::*;

    logic       head_valid;
    line_addr_t head_addr;
    logic       retire;
    logic       full;

    modport queue (
        output head_valid,
        output head_addr,
        output full,
        input  retire
    );

    modport fsm (
        input  head_valid,
        input  head_addr,
        output retire
    );
endinterface

// Returning data beats of the line being filled
interface fill_beat_if;
    logic                           beat_valid;
    logic [`CCU_BUS_DATA_WIDTH-1:0] beat_data;
    logic                           collect;
    logic                           beat_last;
    logic                           clear;

    modport fsm (
        input  beat_last,
        output collect,
        output clear
    );

    modport counter (
        input  beat_valid,
        input  collect,
        input  clear,
        output beat_last
    );

    modport buffer (
        input  beat_valid,
        input  beat_data,
        input  collect,
        input  clear
    );
endinterface

`default_nettype wire

/* ccu_pkg.sv */
`default_nettype none

`include "ccu_settings.svh"

package ccu_pkg;

    // Line address with the byte offset stripped
    typedef logic [`CCU_ADDR_WIDTH-`CCU_IC_OFFSET_WIDTH-1:0] line_addr_t;

    // One full instruction cache line
    typedef logic [`CCU_IC_LINE_SIZE*8-1:0] line_data_t;

    // Fill sequencer states
    // IDLE: waiting for a pending miss
    // REQ:  request held on the bus until acked
    // DATA: collecting beats
    // DONE: line handed to the cache, entry retired
    typedef enum logic [1:0] {
        FILL_IDLE = 2'b00,
        FILL_REQ  = 2'b01,
        FILL_DATA = 2'b10,
        FILL_DONE = 2'b11
    } fill_state_t;

endpackage

`default_nettype wire

/* ccu_settings.svh */
`ifndef CCU_SETTINGS_SVH
`define CCU_SETTINGS_SVH

// Byte address width of the fetch path
`define CCU_ADDR_WIDTH 32

// Instruction cache line geometry
`define CCU_IC_LINE_SIZE 32
`define CCU_IC_OFFSET_WIDTH 5

// One memory bus beat, in bits
`define CCU_BUS_DATA_WIDTH 64

// Beats needed to assemble one line
`define CCU_BEATS_PER_LINE 4

// Outstanding instruction misses
`define CCU_IFQ_DEPTH 4

`endif
